// File: src/lmem_pkg.sv
`default_nettype none

package lmem_pkg;

    //------------------------------------------------------------
    // address and line geometry
    //------------------------------------------------------------
    localparam int ADDR_W   = 32;
    localparam int ID_W     = 4;
    localparam int LINE_W   = 128;                       // 16-byte line
    localparam int OFFSET_W = 4;
    localparam int INDEX_W  = 4;                         // 16 entries
    localparam int TAG_F_W  = ADDR_W - INDEX_W - OFFSET_W;
    localparam int ENTRIES  = 1 << INDEX_W;

    //------------------------------------------------------------
    // tag word layout, msb first: valid, dirty, tag field, blanks
    //------------------------------------------------------------
    localparam int TAG_S     = 32;
    localparam int VALID_BIT = TAG_S - 1;
    localparam int DIRTY_BIT = TAG_S - 2;
    localparam int BLANK_W   = TAG_S - 2 - TAG_F_W;      // 6 zero bits
    localparam int RDATA_W   = TAG_S + LINE_W;           // tag word on top

    // slow memory model
    localparam int READ_LAT = 3;
    localparam int LAT_W    = $clog2(READ_LAT + 1);

    typedef enum logic [1:0] {
        W_IDLE,
        W_ACCEPT,
        W_DATA,
        W_RESP
    } wr_state_e;

    typedef enum logic [1:0] {
        R_IDLE,
        R_ACCEPT,
        R_WAIT,
        R_RESP
    } rd_state_e;

endpackage

`default_nettype wire

// File: src/lmem_line_array.sv
`timescale 1ns/1ps
`default_nettype none

module lmem_line_array (
    input  wire                                      clk,
    input  wire                                      rst_n,
    // write port
    input  wire                                      wr_en_i,
    input  wire [lmem_pkg::INDEX_W-1:0]              wr_index_i,
    input  wire [lmem_pkg::TAG_F_W-1:0]              wr_tag_field_i,
    input  wire                                      wr_dirty_i,
    input  wire [lmem_pkg::LINE_W-1:0]               wr_line_i,
    // tag lookup
    input  wire [lmem_pkg::INDEX_W-1:0]              lk_index_i,
    input  wire [lmem_pkg::TAG_F_W-1:0]              lk_tag_field_i,
    output logic                                     lk_match_o,
    // read port
    input  wire                                      rd_en_i,
    input  wire [lmem_pkg::INDEX_W-1:0]              rd_index_i,
    output logic [lmem_pkg::TAG_S-1:0]               rd_tag_word_o,
    output logic [lmem_pkg::RDATA_W-lmem_pkg::TAG_S-1:0] rd_line_o
);
    import lmem_pkg::*;

    logic [TAG_S-1:0]  tag_mem  [ENTRIES];
    logic [LINE_W-1:0] line_mem [ENTRIES];
    logic [TAG_S-1:0]  lk_word;

    //------------------------------------------------------------
    // storage, cleared to zero on reset
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < ENTRIES; i++) begin
                tag_mem[i]  <= '0;
                line_mem[i] <= '0;
            end
        end else if (wr_en_i) begin
            tag_mem[wr_index_i]  <= {1'b1, wr_dirty_i, wr_tag_field_i, {BLANK_W{1'b0}}};
            line_mem[wr_index_i] <= wr_line_i;
        end
    end

    // hit only on a valid entry with the same tag field
    assign lk_word    = tag_mem[lk_index_i];
    assign lk_match_o = lk_word[VALID_BIT] &&
                        (lk_word[DIRTY_BIT-1 -: TAG_F_W] == lk_tag_field_i);

    //------------------------------------------------------------
    // registered read
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_tag_word_o <= tag_mem[rd_index_i];
            rd_line_o     <= line_mem[rd_index_i];
        end
    end

endmodule

`default_nettype wire

// File: src/lmem_access_timer.sv
`timescale 1ns/1ps
`default_nettype none

module lmem_access_timer (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  start_i,
    output logic done_o
);
    import lmem_pkg::*;

    logic [LAT_W-1:0] count;

    // load on start, then count down and park at zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (start_i) begin
            count <= LAT_W'(READ_LAT);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // last cycle of the access window
    assign done_o = (count == LAT_W'(1));

endmodule

`default_nettype wire

// File: src/lmem_wr_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module lmem_wr_fsm (
    input  wire                          clk,
    input  wire                          rst_n,
    // AW channel
    input  wire [lmem_pkg::ID_W-1:0]     awid_i,
    input  wire [lmem_pkg::ADDR_W-1:0]   awaddr_i,
    input  wire                          awvalid_i,
    output logic                         awready_o,
    // W channel
    input  wire [lmem_pkg::LINE_W-1:0]   wdata_i,
    input  wire                          wvalid_i,
    output logic                         wready_o,
    // B channel
    output logic [lmem_pkg::ID_W-1:0]    bid_o,
    output logic                         bvalid_o,
    input  wire                          bready_i,
    // array lookup and write port
    output logic [lmem_pkg::INDEX_W-1:0] lk_index_o,
    output logic [lmem_pkg::TAG_F_W-1:0] lk_tag_field_o,
    input  wire                          lk_match_i,
    output logic                         wr_en_o,
    output logic [lmem_pkg::INDEX_W-1:0] wr_index_o,
    output logic [lmem_pkg::TAG_F_W-1:0] wr_tag_field_o,
    output logic                         wr_dirty_o,
    output logic [lmem_pkg::LINE_W-1:0]  wr_line_o
);
    import lmem_pkg::*;

    wr_state_e         state, state_n;
    logic [ID_W-1:0]   wid_q;

    //------------------------------------------------------------
    // state register and AW capture
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= W_IDLE;
        end else begin
            state <= state_n;
        end
    end

    always_ff @(posedge clk) begin
        if (state == W_ACCEPT) begin
            wid_q          <= awid_i;
            wr_index_o     <= lk_index_o;
            wr_tag_field_o <= lk_tag_field_o;
            wr_dirty_o     <= lk_match_i;    // same tag already there
        end
    end

    // lookup straight from the held address
    assign lk_index_o     = awaddr_i[OFFSET_W +: INDEX_W];
    assign lk_tag_field_o = awaddr_i[ADDR_W-1 -: TAG_F_W];

    always_comb begin
        state_n = state;
        case (state)
            W_IDLE:   if (awvalid_i) state_n = W_ACCEPT;
            W_ACCEPT: state_n = W_DATA;
            W_DATA:   if (wvalid_i) state_n = W_RESP;
            W_RESP:   if (bready_i) state_n = W_IDLE;
            default:  state_n = W_IDLE;
        endcase
    end

    assign awready_o = (state == W_ACCEPT);
    assign wready_o  = (state == W_DATA);
    assign wr_en_o   = wready_o && wvalid_i;   // W handshake edge
    assign wr_line_o = wdata_i;
    assign bvalid_o  = (state == W_RESP);
    assign bid_o     = wid_q;

endmodule

`default_nettype wire

// File: src/lmem_rd_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module lmem_rd_fsm (
    input  wire                                          clk,
    input  wire                                          rst_n,
    // AR channel
    input  wire [lmem_pkg::ID_W-1:0]                     arid_i,
    input  wire [lmem_pkg::ADDR_W-1:0]                   araddr_i,
    input  wire                                          arvalid_i,
    output logic                                         arready_o,
    // R channel
    output logic [lmem_pkg::ID_W-1:0]                    rid_o,
    output logic [lmem_pkg::RDATA_W-1:0]                 rdata_o,
    output logic                                         rvalid_o,
    input  wire                                          rready_i,
    // array read port
    output logic                                         rd_en_o,
    output logic [lmem_pkg::INDEX_W-1:0]                 rd_index_o,
    input  wire [lmem_pkg::TAG_S-1:0]                    rd_tag_word_i,
    input  wire [lmem_pkg::RDATA_W-lmem_pkg::TAG_S-1:0]  rd_line_i,
    // access timer
    output logic                                         tmr_start_o,
    input  wire                                          tmr_done_i
);
    import lmem_pkg::*;

    rd_state_e state, state_n;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= R_IDLE;
        end else begin
            state <= state_n;
        end
    end

    // AR payload is stable while arready is up
    always_ff @(posedge clk) begin
        if (state == R_ACCEPT) begin
            rid_o      <= arid_i;
            rd_index_o <= araddr_i[OFFSET_W +: INDEX_W];
        end
    end

    always_comb begin
        state_n = state;
        case (state)
            R_IDLE:   if (arvalid_i) state_n = R_ACCEPT;
            R_ACCEPT: state_n = R_WAIT;
            R_WAIT:   if (tmr_done_i) state_n = R_RESP;
            R_RESP:   if (rready_i) state_n = R_IDLE;
            default:  state_n = R_IDLE;
        endcase
    end

    assign arready_o   = (state == R_ACCEPT);
    assign tmr_start_o = arready_o;
    assign rd_en_o     = (state == R_WAIT) && tmr_done_i;  // last wait edge
    assign rvalid_o    = (state == R_RESP);
    assign rdata_o     = {rd_tag_word_i, rd_line_i};      // held by the array regs

endmodule

`default_nettype wire

// File: src/lmem_top.sv
`timescale 1ns/1ps
`default_nettype none

module lmem_top (
    input  wire                          clk,
    input  wire                          rst_n,
    // AR channel
    input  wire [lmem_pkg::ID_W-1:0]     arid_i,
    input  wire [lmem_pkg::ADDR_W-1:0]   araddr_i,
    input  wire                          arvalid_i,
    output logic                         arready_o,
    // R channel
    output logic [lmem_pkg::ID_W-1:0]    rid_o,
    output logic [lmem_pkg::RDATA_W-1:0] rdata_o,
    output logic                         rvalid_o,
    input  wire                          rready_i,
    // AW channel
    input  wire [lmem_pkg::ID_W-1:0]     awid_i,
    input  wire [lmem_pkg::ADDR_W-1:0]   awaddr_i,
    input  wire                          awvalid_i,
    output logic                         awready_o,
    // W channel
    input  wire [lmem_pkg::LINE_W-1:0]   wdata_i,
    input  wire                          wvalid_i,
    output logic                         wready_o,
    // B channel
    output logic [lmem_pkg::ID_W-1:0]    bid_o,
    output logic                         bvalid_o,
    input  wire                          bready_i
);
    import lmem_pkg::*;

    //------------------------------------------------------------
    // internal nets
    //------------------------------------------------------------
    logic [INDEX_W-1:0] lk_index;
    logic [TAG_F_W-1:0] lk_tag_field;
    logic               lk_match;
    logic               wr_en;
    logic [INDEX_W-1:0] wr_index;
    logic [TAG_F_W-1:0] wr_tag_field;
    logic               wr_dirty;
    logic [LINE_W-1:0]  wr_line;
    logic               rd_en;
    logic [INDEX_W-1:0] rd_index;
    logic [TAG_S-1:0]   rd_tag_word;
    logic [LINE_W-1:0]  rd_line;
    logic               tmr_start;
    logic               tmr_done;

    lmem_wr_fsm u_wr_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .awid_i         (awid_i),
        .awaddr_i       (awaddr_i),
        .awvalid_i      (awvalid_i),
        .awready_o      (awready_o),
        .wdata_i        (wdata_i),
        .wvalid_i       (wvalid_i),
        .wready_o       (wready_o),
        .bid_o          (bid_o),
        .bvalid_o       (bvalid_o),
        .bready_i       (bready_i),
        .lk_index_o     (lk_index),
        .lk_tag_field_o (lk_tag_field),
        .lk_match_i     (lk_match),
        .wr_en_o        (wr_en),
        .wr_index_o     (wr_index),
        .wr_tag_field_o (wr_tag_field),
        .wr_dirty_o     (wr_dirty),
        .wr_line_o      (wr_line)
    );

    lmem_rd_fsm u_rd_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .arid_i        (arid_i),
        .araddr_i      (araddr_i),
        .arvalid_i     (arvalid_i),
        .arready_o     (arready_o),
        .rid_o         (rid_o),
        .rdata_o       (rdata_o),
        .rvalid_o      (rvalid_o),
        .rready_i      (rready_i),
        .rd_en_o       (rd_en),
        .rd_index_o    (rd_index),
        .rd_tag_word_i (rd_tag_word),
        .rd_line_i     (rd_line),
        .tmr_start_o   (tmr_start),
        .tmr_done_i    (tmr_done)
    );

    lmem_access_timer u_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (tmr_start),
        .done_o  (tmr_done)
    );

    lmem_line_array u_array (
        .clk            (clk),
        .rst_n          (rst_n),
        .wr_en_i        (wr_en),
        .wr_index_i     (wr_index),
        .wr_tag_field_i (wr_tag_field),
        .wr_dirty_i     (wr_dirty),
        .wr_line_i      (wr_line),
        .lk_index_i     (lk_index),
        .lk_tag_field_i (lk_tag_field),
        .lk_match_o     (lk_match),
        .rd_en_i        (rd_en),
        .rd_index_i     (rd_index),
        .rd_tag_word_o  (rd_tag_word),
        .rd_line_o      (rd_line)
    );

endmodule

`default_nettype wire

// File: dv/tb_lmem_util.svh
`ifndef TB_LMEM_UTIL_SVH
`define TB_LMEM_UTIL_SVH

//------------------------------------------------------------
// reference model, one tag word and one line per entry
//------------------------------------------------------------
logic [TAG_S-1:0]  model_tag  [ENTRIES];
logic [LINE_W-1:0] model_line [ENTRIES];

logic [31:0] lfsr_state;

// galois step, taps 32 31 29 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 32'hD000_0001;
    end
    return s >> 1;
endfunction

// n random bits, one lfsr step per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

task automatic check_value(input string name, input logic [RDATA_W-1:0] got,
                           input logic [RDATA_W-1:0] exp);
    if (got !== exp) begin
        $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
        $display("sim failed");
        $fatal(1, "mismatch on %s", name);
    end
endtask

`endif

// File: dv/tb_lmem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lmem;
    import lmem_pkg::*;

    localparam int NUM_OPS = 300;
    localparam int TIMEOUT = 40;    // cycles per handshake wait

    logic                clk;
    logic                rst_n;
    logic [ID_W-1:0]     arid;
    logic [ADDR_W-1:0]   araddr;
    logic                arvalid;
    logic                arready;
    logic [ID_W-1:0]     rid;
    logic [RDATA_W-1:0]  rdata;
    logic                rvalid;
    logic                rready;
    logic [ID_W-1:0]     awid;
    logic [ADDR_W-1:0]   awaddr;
    logic                awvalid;
    logic                awready;
    logic [LINE_W-1:0]   wdata;
    logic                wvalid;
    logic                wready;
    logic [ID_W-1:0]     bid;
    logic                bvalid;
    logic                bready;
    int                  n_dirty;     // same-tag rewrites seen
    int                  n_replace;   // tag changes on a valid entry
    int                  n_empty;     // reads of unwritten entries

    `include "tb_lmem_util.svh"

    lmem_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .arid_i    (arid),
        .araddr_i  (araddr),
        .arvalid_i (arvalid),
        .arready_o (arready),
        .rid_o     (rid),
        .rdata_o   (rdata),
        .rvalid_o  (rvalid),
        .rready_i  (rready),
        .awid_i    (awid),
        .awaddr_i  (awaddr),
        .awvalid_i (awvalid),
        .awready_o (awready),
        .wdata_i   (wdata),
        .wvalid_i  (wvalid),
        .wready_o  (wready),
        .bid_o     (bid),
        .bvalid_o  (bvalid),
        .bready_i  (bready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_timeout(input string what);
        $display("timeout: %s did not arrive within %0d cycles", what, TIMEOUT);
        $display("sim failed");
        $fatal(1, "handshake timeout");
    endtask

    // small pool so that tag hits happen often
    function automatic logic [TAG_F_W-1:0] pick_tag(input logic [1:0] sel);
        case (sel)
            2'd0:    return 24'h5a17e3;
            2'd1:    return 24'h001f40;
            2'd2:    return 24'h9c2b8d;
            default: return 24'hffffff;
        endcase
    endfunction

    //------------------------------------------------------------
    // one write, AW then W then B
    //------------------------------------------------------------
    task automatic write_entry(input logic [INDEX_W-1:0] idx, input logic [TAG_F_W-1:0] tag,
                               input logic [ID_W-1:0] id, input logic [LINE_W-1:0] line,
                               input int w_stall, input int b_stall);
        logic old_valid;
        logic dirty;
        int   n;
        awid      = id;
        awaddr    = {tag, idx, OFFSET_W'(rand_bits(OFFSET_W))};
        awvalid   = 1'b1;
        old_valid = model_tag[idx][VALID_BIT];
        dirty     = old_valid && (model_tag[idx][DIRTY_BIT-1 -: TAG_F_W] == tag);
        n = 0;
        while (!awready) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) report_timeout("awready");
        end
        @(negedge clk);
        awvalid = 1'b0;
        check_value("awready", awready, 1'b0);    // single cycle only
        repeat (w_stall) begin
            check_value("wready", wready, 1'b1);
            @(negedge clk);
        end
        wdata  = line;
        wvalid = 1'b1;
        n = 0;
        while (!wready) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) report_timeout("wready");
        end
        @(negedge clk);
        wvalid          = 1'b0;
        model_tag[idx]  = {1'b1, dirty, tag, {BLANK_W{1'b0}}};
        model_line[idx] = line;
        if (dirty) n_dirty++;
        else if (old_valid) n_replace++;
        n = 0;
        while (!bvalid) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) report_timeout("bvalid");
        end
        repeat (b_stall) begin    // response must hold under back-pressure
            check_value("bvalid", bvalid, 1'b1);
            check_value("bid", bid, id);
            @(negedge clk);
        end
        check_value("bid", bid, id);
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
        check_value("bvalid", bvalid, 1'b0);
    endtask

    //------------------------------------------------------------
    // one read, AR then R, with the latency check
    //------------------------------------------------------------
    task automatic read_entry(input logic [INDEX_W-1:0] idx, input logic [TAG_F_W-1:0] tag,
                              input logic [ID_W-1:0] id, input int r_stall);
        logic [RDATA_W-1:0] exp;
        int                 n;
        arid    = id;
        araddr  = {tag, idx, OFFSET_W'(rand_bits(OFFSET_W))};
        arvalid = 1'b1;
        exp     = {model_tag[idx], model_line[idx]};
        if (model_tag[idx] == '0) n_empty++;
        n = 0;
        while (!arready) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) report_timeout("arready");
        end
        @(negedge clk);
        arvalid = 1'b0;
        n = 1;    // cycles since the arready cycle
        while (!rvalid) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) report_timeout("rvalid");
        end
        check_value("read latency", n, READ_LAT + 1);
        repeat (r_stall) begin
            check_value("rvalid", rvalid, 1'b1);
            check_value("rid", rid, id);
            check_value("rdata", rdata, exp);
            @(negedge clk);
        end
        check_value("rid", rid, id);
        check_value("rdata", rdata, exp);
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
        check_value("rvalid", rvalid, 1'b0);
    endtask

    initial begin
        logic [INDEX_W-1:0] idx;
        logic [TAG_F_W-1:0] tag;
        logic [ID_W-1:0]    id;
        logic [LINE_W-1:0]  line;
        lfsr_state = 32'h43e594ed;
        rst_n      = 1'b0;
        arid       = '0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        awid       = '0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        n_dirty    = 0;
        n_replace  = 0;
        n_empty    = 0;
        for (int i = 0; i < ENTRIES; i++) begin
            model_tag[i]  = '0;
            model_line[i] = '0;
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("arready", arready, 1'b0);
        check_value("rvalid", rvalid, 1'b0);
        check_value("awready", awready, 1'b0);
        check_value("wready", wready, 1'b0);
        check_value("bvalid", bvalid, 1'b0);
        read_entry(4'd9, pick_tag(2'd0), 4'h3, 2);    // untouched entry reads zero
        for (int op = 0; op < NUM_OPS; op++) begin
            idx = INDEX_W'(rand_bits(INDEX_W));
            tag = pick_tag(2'(rand_bits(2)));
            id  = ID_W'(rand_bits(ID_W));
            if (rand_bits(1) == 1) begin
                line = '0;
                for (int k = 0; k < LINE_W / 32; k++) begin
                    line = {line[LINE_W-33:0], rand_bits(32)};
                end
                write_entry(idx, tag, id, line, rand_bits(3), rand_bits(3));
            end else begin
                read_entry(idx, tag, id, rand_bits(3));
            end
        end
        if (n_dirty > 0 && n_replace > 0 && n_empty > 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("not every write and read case was reached: dirty %0d replace %0d empty %0d",
                     n_dirty, n_replace, n_empty);
            $display("sim failed");
            $fatal(1, "write and read cases missed");
        end
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+dv
src/lmem_pkg.sv
src/lmem_line_array.sv
src/lmem_access_timer.sv
src/lmem_wr_fsm.sv
src/lmem_rd_fsm.sv
src/lmem_top.sv
dv/tb_lmem.sv
